//--- Makefile
# Verilator build and run for the MDU testbench.

VERILATOR  ?= verilator
TOP        ?= tb_mdu
FLIST      ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module mdu_top

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- mdu_ctl_pkg.sv
package mdu_ctl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execution state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		st_idle     = 2'd0,
		st_mul_wait = 2'd1,
		st_div_wait = 2'd2
	} mdu_state_e;

	// Result word for mfhi, mflo and mul.
	typedef struct packed {
		logic [7:0]  tag;
		logic [31:0] data;
	} mdu_res_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Flow control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Free credits, 0 up to the queue depth.
	typedef logic [2:0] mdu_credit_t;

endpackage

//--- mdu_exec.sv
`timescale 1ns/1ns
`include "mdu_macros.svh"

module mdu_exec (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  head_valid,
	input  mdu_op_pkg::mdu_cmd_t  head_cmd,
	output logic                  pop,
	output logic                  res_valid,
	output mdu_ctl_pkg::mdu_res_t res
);
	import mdu_op_pkg::*;
	import mdu_ctl_pkg::*;

	// Divide is the longest wait, so it sizes the counter.
	localparam int cnt_w = $clog2(`MDU_DIV_CYCLES);

	mdu_state_e        state;
	logic [cnt_w-1:0]  cnt;
	logic [31:0]       hi;
	logic [31:0]       lo;
	logic [63:0]       hilo;
	logic [63:0]       pend;      // Result waiting for commit.
	logic [7:0]        pend_tag;
	logic              pend_res;  // Commit goes to res, not HI/LO.
	logic              commit;

	logic signed [63:0] prod_s;
	logic [63:0]        prod_u;
	logic [31:0]        quot_s;
	logic [31:0]        rem_s;
	logic [31:0]        quot_u;
	logic [31:0]        rem_u;
	logic               rt_zero;
	logic               start_mul;
	logic               start_div;
	logic [63:0]        pend_next;

	assign pop    = (state == st_idle) && head_valid;  // In order, one at a time.
	assign commit = (state != st_idle) && (cnt == '0);
	assign hilo   = {hi, lo};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Arithmetic on the head entry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign prod_s  = $signed(head_cmd.rs) * $signed(head_cmd.rt);
	assign prod_u  = head_cmd.rs * head_cmd.rt;
	assign quot_s  = $signed(head_cmd.rs) / $signed(head_cmd.rt);
	assign rem_s   = $signed(head_cmd.rs) % $signed(head_cmd.rt);
	assign quot_u  = head_cmd.rs / head_cmd.rt;
	assign rem_u   = head_cmd.rs % head_cmd.rt;
	assign rt_zero = (head_cmd.rt == '0);

	always_comb begin
		start_mul = 1'b0;
		start_div = 1'b0;
		pend_next = hilo;  // Zero divisor keeps HI:LO.
		case (head_cmd.op)
			op_mult, op_mul: begin
				start_mul = 1'b1;
				pend_next = prod_s;
			end
			op_multu: begin
				start_mul = 1'b1;
				pend_next = prod_u;
			end
			op_madd: begin
				start_mul = 1'b1;
				pend_next = hilo + prod_s;
			end
			op_maddu: begin
				start_mul = 1'b1;
				pend_next = hilo + prod_u;
			end
			op_msub: begin
				start_mul = 1'b1;
				pend_next = hilo - prod_s;
			end
			op_msubu: begin
				start_mul = 1'b1;
				pend_next = hilo - prod_u;
			end
			op_div: begin
				start_div = 1'b1;
				if (!rt_zero) begin
					pend_next = {rem_s, quot_s};  // Remainder in HI.
				end
			end
			op_divu: begin
				start_div = 1'b1;
				if (!rt_zero) begin
					pend_next = {rem_u, quot_u};
				end
			end
			default: begin
				// Moves and reads need no pending result.
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM, HI/LO and result strobe
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			cnt       <= '0;
			hi        <= '0;
			lo        <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (pop) begin
						case (head_cmd.op)
							op_mthi: hi <= head_cmd.rs;
							op_mtlo: lo <= head_cmd.rs;
							op_mfhi, op_mflo: res_valid <= 1'b1;
							default: begin
							end
						endcase
						if (start_mul) begin
							state <= st_mul_wait;
							cnt   <= cnt_w'(`MDU_MUL_CYCLES - 1);
						end else if (start_div) begin
							state <= st_div_wait;
							cnt   <= cnt_w'(`MDU_DIV_CYCLES - 1);
						end
					end
				end
				st_mul_wait, st_div_wait: begin
					if (commit) begin
						state <= st_idle;
						if (pend_res) begin
							res_valid <= 1'b1;  // mul result.
						end else begin
							hi <= pend[63:32];
							lo <= pend[31:0];
						end
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Pending result and output word.
	always_ff @(posedge clk) begin
		if (pop) begin
			pend     <= pend_next;
			pend_tag <= head_cmd.tag;
			pend_res <= (head_cmd.op == op_mul);
			res.tag  <= head_cmd.tag;
			res.data <= (head_cmd.op == op_mfhi) ? hi : lo;
		end else if (commit) begin
			res.tag  <= pend_tag;
			res.data <= pend[31:0];
		end
	end

endmodule

//--- mdu_issue.sv
`timescale 1ns/1ns
`include "mdu_macros.svh"

module mdu_issue (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  mdu_op_pkg::mdu_cmd_t cmd,
	output logic                 cmd_ready,
	input  logic                 credit,
	output logic                 push,
	output mdu_op_pkg::mdu_cmd_t push_cmd
);
	import mdu_ctl_pkg::*;

	mdu_credit_t credits;
	logic        accept;

	// A credit coming back this cycle is usable at once.
	assign cmd_ready = (credits != '0) || credit;
	assign accept    = cmd_valid && cmd_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Credit counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= mdu_credit_t'(`MDU_QUEUE_DEPTH);  // Queue starts empty.
			push    <= 1'b0;
		end else begin
			push <= accept;  // Push one cycle after acceptance.
			case ({accept, credit})
				2'b10: begin
					credits <= credits - 1'b1;
				end
				2'b01: begin
					credits <= credits + 1'b1;
				end
				default: begin
					// Spend and return together, or neither.
				end
			endcase
		end
	end

	// Command register feeding the queue.
	always_ff @(posedge clk) begin
		if (accept) begin
			push_cmd <= cmd;
		end
	end

endmodule

//--- mdu_macros.svh
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Entries in the request queue, also the starting credit count.
// Must be a power of two.
`define MDU_QUEUE_DEPTH 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execution latencies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Busy cycles for mult, multu, mul and the accumulate group.
`define MDU_MUL_CYCLES 5

// Busy cycles for div and divu. The longest latency.
`define MDU_DIV_CYCLES 10

`endif

//--- mdu_op_pkg.sv
package mdu_op_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		op_mult  = 4'd0,
		op_multu = 4'd1,
		op_div   = 4'd2,
		op_divu  = 4'd3,
		op_mfhi  = 4'd4,
		op_mflo  = 4'd5,
		op_mthi  = 4'd6,
		op_mtlo  = 4'd7,
		op_madd  = 4'd8,
		op_maddu = 4'd9,
		op_msub  = 4'd10,
		op_msubu = 4'd11,
		op_mul   = 4'd12  // Low word only, HI/LO untouched.
	} mdu_op_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		mdu_op_e     op;
		logic [31:0] rs;   // Also the source for mthi/mtlo.
		logic [31:0] rt;
		logic [7:0]  tag;  // Echoed in results.
	} mdu_cmd_t;

endpackage

//--- mdu_req_fifo.sv
`timescale 1ns/1ns
`include "mdu_macros.svh"

module mdu_req_fifo (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 push,
	input  mdu_op_pkg::mdu_cmd_t push_cmd,
	output logic                 head_valid,
	output mdu_op_pkg::mdu_cmd_t head_cmd,
	input  logic                 pop,
	output logic                 credit
);
	import mdu_op_pkg::*;

	localparam int ptr_w = $clog2(`MDU_QUEUE_DEPTH);

	mdu_cmd_t         mem [`MDU_QUEUE_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;
	logic             do_pop;

	assign head_valid = (count != '0);
	assign head_cmd   = mem[rd_ptr];
	assign do_pop     = pop && head_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers, occupancy and credit return
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			// Pointers wrap on their own, depth is a power of two.
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			credit <= do_pop;  // One credit back per pop.
			case ({push, do_pop})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					// Occupancy unchanged.
				end
			endcase
		end
	end

	// Storage. No full check, credits bound the occupancy.
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

endmodule

//--- mdu_top.sv
`timescale 1ns/1ns

module mdu_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cmd_valid,
	input  mdu_op_pkg::mdu_cmd_t  cmd,
	output logic                  cmd_ready,
	output logic                  res_valid,
	output mdu_ctl_pkg::mdu_res_t res
);
	import mdu_op_pkg::*;

	logic     push;
	mdu_cmd_t push_cmd;
	logic     credit;
	logic     head_valid;
	mdu_cmd_t head_cmd;
	logic     pop;

	mdu_issue issue0 (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.credit    (credit),
		.push      (push),
		.push_cmd  (push_cmd)
	);

	mdu_req_fifo fifo0 (
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.push_cmd   (push_cmd),
		.head_valid (head_valid),
		.head_cmd   (head_cmd),
		.pop        (pop),
		.credit     (credit)
	);

	mdu_exec exec0 (
		.clk        (clk),
		.reset      (reset),
		.head_valid (head_valid),
		.head_cmd   (head_cmd),
		.pop        (pop),
		.res_valid  (res_valid),
		.res        (res)
	);

endmodule

//--- tb.f
+incdir+.
mdu_op_pkg.sv
mdu_ctl_pkg.sv
mdu_issue.sv
mdu_req_fifo.sv
mdu_exec.sv
mdu_top.sv
tb_mdu.sv

//--- tb_mdu.sv
`timescale 1ns/1ns
`include "mdu_macros.svh"

module tb_mdu;
	import mdu_op_pkg::*;
	import mdu_ctl_pkg::*;

	// Six tests, at most 60 commands each, a divide plus two cycles per command.
	localparam int max_cycles = 6 * 60 * (`MDU_DIV_CYCLES + 2);

	logic        clk;
	logic        reset;
	logic        cmd_valid;
	mdu_cmd_t    cmd;
	logic        cmd_ready;
	logic        res_valid;
	mdu_res_t    res;

	logic [31:0] model_hi;
	logic [31:0] model_lo;
	logic [39:0] exp_q[$];  // {tag, data} in issue order.
	logic [39:0] exp_res;
	logic [7:0]  next_tag;
	int          cycles = 0;
	int          seed;
	logic        in_burst;
	logic        saw_stall;

	mdu_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.res_valid (res_valid),
		.res       (res)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("tests failed");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [63:0] prod_signed(input logic [31:0] a, input logic [31:0] b);
		longint sa;
		longint sb;
		sa = $signed(a);  // Sign extends to 64 bits.
		sb = $signed(b);
		return sa * sb;
	endfunction

	function automatic logic [63:0] prod_unsigned(input logic [31:0] a, input logic [31:0] b);
		logic [63:0] ua;
		logic [63:0] ub;
		ua = {32'h0, a};
		ub = {32'h0, b};
		return ua * ub;
	endfunction

	task automatic model_apply(input mdu_cmd_t c);
		int          sa;
		int          sb;
		logic [63:0] acc;
		logic [63:0] ps;
		logic [63:0] pu;
		acc = {model_hi, model_lo};
		sa  = $signed(c.rs);
		sb  = $signed(c.rt);
		ps  = prod_signed(c.rs, c.rt);
		pu  = prod_unsigned(c.rs, c.rt);
		case (c.op)
			op_mult:  acc = ps;
			op_multu: acc = pu;
			op_madd:  acc = acc + ps;
			op_maddu: acc = acc + pu;
			op_msub:  acc = acc - ps;
			op_msubu: acc = acc - pu;
			op_div: begin
				if (c.rt != 0) begin
					acc = {sa % sb, sa / sb};  // Truncating, remainder takes dividend sign.
				end
			end
			op_divu: begin
				if (c.rt != 0) begin
					acc = {c.rs % c.rt, c.rs / c.rt};
				end
			end
			op_mthi:  acc[63:32] = c.rs;
			op_mtlo:  acc[31:0] = c.rs;
			op_mfhi:  exp_q.push_back({c.tag, model_hi});
			op_mflo:  exp_q.push_back({c.tag, model_lo});
			op_mul:   exp_q.push_back({c.tag, ps[31:0]});  // HI/LO untouched.
			default: begin
			end
		endcase
		{model_hi, model_lo} = acc;
	endtask

	// Results compared in arrival order.
	always @(negedge clk) begin
		if (!reset && res_valid) begin
			if (exp_q.size() == 0) begin
				$display("A result with tag %h arrived while none was pending", res.tag);
				$display("tests failed");
				$fatal(1);
			end else begin
				exp_res = exp_q.pop_front();
				check_value("res.tag", res.tag, exp_res[39:32]);
				check_value("res.data", res.data, exp_res[31:0]);
			end
		end
	end

	always @(negedge clk) begin
		if (in_burst && !cmd_ready) begin
			saw_stall = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Called on a rising edge, returns on the accepting edge.
	task automatic send_cmd(input mdu_cmd_t c);
		cmd_valid <= 1'b1;
		cmd       <= c;
		@(negedge clk);
		while (!cmd_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic issue(input mdu_op_e op, input logic [31:0] rs, input logic [31:0] rt);
		mdu_cmd_t c;
		c.op     = op;
		c.rs     = rs;
		c.rt     = rt;
		c.tag    = next_tag;
		next_tag = next_tag + 8'd1;
		send_cmd(c);
		model_apply(c);
	endtask

	task automatic read_hilo();
		issue(op_mfhi, 32'h0, 32'h0);
		issue(op_mflo, 32'h0, 32'h0);
	endtask

	task automatic finish_test();
		cmd_valid <= 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic test_moves();
		$display("Test: mthi and mtlo");
		issue(op_mthi, 32'hdeadbeef, 32'h0);
		issue(op_mtlo, 32'h12345678, 32'h0);
		read_hilo();
		finish_test();
	endtask

	task automatic test_mults();
		$display("Test: mult and multu");
		issue(op_mult, -32'sd5, 32'd7);
		read_hilo();
		issue(op_mult, 32'h80000000, 32'h7fffffff);
		read_hilo();
		issue(op_multu, 32'hffffffff, 32'hffffffff);
		read_hilo();
		issue(op_mult, 32'hffffffff, 32'hffffffff);  // -1 * -1.
		read_hilo();
		finish_test();
	endtask

	task automatic test_accum();
		$display("Test: accumulate group");
		issue(op_mthi, 32'h0, 32'h0);
		issue(op_mtlo, 32'h0, 32'h0);
		issue(op_madd, -32'sd3, 32'd1000);
		read_hilo();
		issue(op_maddu, 32'hffffffff, 32'd2);
		read_hilo();
		issue(op_msub, 32'd7, -32'sd9);
		read_hilo();
		issue(op_msubu, 32'hffff0000, 32'h00010000);  // Top bit set, sign matters.
		read_hilo();
		finish_test();
	endtask

	task automatic test_divs();
		$display("Test: div and divu");
		issue(op_div, -32'sd17, 32'd5);
		read_hilo();
		issue(op_divu, 32'hfffffff0, 32'd7);
		read_hilo();
		issue(op_div, 32'd100, 32'd0);  // HI/LO must survive.
		read_hilo();
		issue(op_divu, 32'd5, 32'd0);
		read_hilo();
		finish_test();
	endtask

	task automatic test_mul();
		$display("Test: mul");
		issue(op_mthi, 32'hcafef00d, 32'h0);
		issue(op_mtlo, 32'h0badc0de, 32'h0);
		issue(op_mul, -32'sd123456, 32'd789);
		read_hilo();
		finish_test();
	endtask

	task automatic test_backpressure();
		mdu_op_e     op;
		logic [31:0] rs;
		logic [31:0] rt;
		int          k;
		$display("Test: back-pressure burst");
		in_burst  = 1'b1;
		saw_stall = 1'b0;
		issue(op_div, 32'd1000, 32'd7);  // Long head op, queue fills behind it.
		for (k = 1; k < 40; k++) begin
			op = mdu_op_e'({$random(seed)} % 13);
			rs = $random(seed);
			rt = $random(seed);
			if (k % 8 == 5) begin
				rt = 32'h0;
			end
			if (op == op_div && rs == 32'h80000000 && rt == 32'hffffffff) begin
				rt = 32'd1;  // Signed overflow case.
			end
			issue(op, rs, rt);
		end
		finish_test();
		in_burst = 1'b0;
		check_value("cmd_ready_stall", saw_stall, 1'b1);
	endtask

	initial begin
		seed      = 64;
		reset     = 1'b1;
		cmd_valid = 1'b0;
		cmd       = '0;
		next_tag  = 8'd0;
		model_hi  = 32'h0;
		model_lo  = 32'h0;
		in_burst  = 1'b0;
		saw_stall = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("cmd_ready", cmd_ready, 1'b1);
		check_value("res_valid", res_valid, 1'b0);
		@(posedge clk);
		test_moves();
		test_mults();
		test_accum();
		test_divs();
		test_mul();
		test_backpressure();
		$display("all tests passed");
		$finish;
	end

endmodule
